/* score_overlay.f */
+incdir+hdl
hdl/score_overlay_pkg.sv
hdl/vga_timing.sv
hdl/score_regs.sv
hdl/digit_glyph.sv
hdl/video_delay.sv
hdl/overlay_mixer.sv
hdl/score_overlay.sv
bench/score_overlay_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the score overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module score_overlay_tb -f score_overlay.f \
	-o score_overlay_sim

./obj_dir/score_overlay_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
	exit 0
else
	exit 1
fi

/* bench/score_overlay_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "score_overlay_defines.svh"

module score_overlay_tb;

	import score_overlay_pkg::*;

	localparam int clk_period = 4;
	localparam int h_total = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int v_total = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	// Six frames of tests plus slack for reset and bus traffic
	localparam int test_frames = 6;
	localparam int margin_cycles = 50000;
	localparam int timeout_ns = (test_frames * h_total * v_total + margin_cycles) * clk_period;
	localparam int handshake_limit = 32;
	localparam int hold_cycles = 12;

	// Expected VGA pins for one cycle
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic hs;
		logic vs;
		logic blank_n;
	} video_out_t;

	// Pins straight after reset
	localparam video_out_t idle_out = {8'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0};

	logic vga_clk = 1'b0;
	logic reset;
	logic [`AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`AXI_DATA_W-1:0] wdata;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;
	logic [`AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`AXI_DATA_W-1:0] rdata;
	axi_resp_t rresp;
	logic rvalid;
	logic rready;
	logic pixel_request;
	logic [7:0] pixel_in_r;
	logic [7:0] pixel_in_g;
	logic [7:0] pixel_in_b;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_blank_n;

	// Reference model state
	int model_h;
	int model_v;
	video_out_t hist0;
	video_out_t hist1;
	logic m_enable = 1'b0;
	int m_score_a = 0;
	int m_score_b = 0;
	int seed = 28;
	string test_name = "post_reset";
	logic running = 1'b0;
	event vblank_start;

	score_overlay DUT (.*);

	always #(clk_period / 2) vga_clk = ~vga_clk;

	// ============================================================
	// Reporting
	// ============================================================
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string test, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
			fail_run("a DUT output differs from the reference model");
		end
	endtask

	// ============================================================
	// Register model
	// ============================================================
	function automatic logic [6:0] saturate(input logic [31:0] data);
		if (data[6:0] > 7'(`SCORE_MAX))
			return 7'(`SCORE_MAX);
		return data[6:0];
	endfunction

	function automatic logic [1:0] expected_resp(input logic [`AXI_ADDR_W-1:0] addr);
		if (addr == `ADDR_CTRL || addr == `ADDR_SCORE_A || addr == `ADDR_SCORE_B)
			return OKAY;
		return SLVERR;
	endfunction

	// Unmapped reads give zero
	function automatic logic [31:0] expected_read(input logic [`AXI_ADDR_W-1:0] addr);
		case (addr)
			`ADDR_CTRL: return 32'(m_enable);
			`ADDR_SCORE_A: return 32'(m_score_a);
			`ADDR_SCORE_B: return 32'(m_score_b);
			default: return 32'h0;
		endcase
	endfunction

	task automatic model_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		case (addr)
			`ADDR_CTRL: m_enable = data[0];
			`ADDR_SCORE_A: m_score_a = int'(saturate(data));
			`ADDR_SCORE_B: m_score_b = int'(saturate(data));
			default: ;
		endcase
	endtask

	// Tens then ones, score A first
	function automatic int model_digit(input int k);
		case (k)
			0: return m_score_a / 10;
			1: return m_score_a % 10;
			2: return m_score_b / 10;
			default: return m_score_b % 10;
		endcase
	endfunction

	// ============================================================
	// Glyph model
	// ============================================================
	function automatic string segment_set(input int d);
		case (d)
			0: return "abcdef";
			1: return "bc";
			2: return "abdeg";
			3: return "abcdg";
			4: return "bcfg";
			5: return "acdfg";
			6: return "acdefg";
			7: return "abc";
			8: return "abcdefg";
			default: return "abcdfg";
		endcase
	endfunction

	function automatic logic in_rect(input int x, input int y, input int x0, input int x1,
		input int y0, input int y1);
		return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
	endfunction

	// Rectangles in glyph coordinates
	function automatic logic on_segment(input byte seg, input int lx, input int ly);
		case (seg)
			"a": return in_rect(lx, ly, 0, 15, 0, 3);
			"b": return in_rect(lx, ly, 12, 15, 0, 11);
			"c": return in_rect(lx, ly, 12, 15, 12, 23);
			"d": return in_rect(lx, ly, 0, 15, 20, 23);
			"e": return in_rect(lx, ly, 0, 3, 12, 23);
			"f": return in_rect(lx, ly, 0, 3, 0, 11);
			"g": return in_rect(lx, ly, 0, 15, 10, 13);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic glyph_lit(input int x, input int y);
		int lx;
		int ly;
		int k;
		int i;
		string segs;
		logic hit;
		hit = 1'b0;
		for (k = 0; k < `NUM_DIGITS; k++) begin
			lx = x - (`GLYPH_X0 + `GLYPH_PITCH * k);
			ly = y - `GLYPH_Y;
			if (in_rect(lx, ly, 0, `GLYPH_W - 1, 0, `GLYPH_H - 1)) begin
				segs = segment_set(model_digit(k));
				for (i = 0; i < segs.len(); i++) begin
					if (on_segment(segs[i], lx, ly))
						hit = 1'b1;
				end
			end
		end
		return hit;
	endfunction

	function automatic video_out_t expected_output(input int h, input int v,
		input logic [23:0] rgb);
		video_out_t e;
		logic active;
		active = (h < `H_ACTIVE) && (v < `V_ACTIVE);
		// Syncs low inside their windows
		e.hs = !((h >= `H_ACTIVE + `H_FRONT) && (h < `H_ACTIVE + `H_FRONT + `H_SYNC));
		e.vs = !((v >= `V_ACTIVE + `V_FRONT) && (v < `V_ACTIVE + `V_FRONT + `V_SYNC));
		e.blank_n = active;
		if (!active)
			{e.r, e.g, e.b} = 24'h000000;
		else if (m_enable && glyph_lit(h, v))
			{e.r, e.g, e.b} = 24'hffffff;
		else
			{e.r, e.g, e.b} = rgb;
		return e;
	endfunction

	// ============================================================
	// Video side
	// ============================================================
	task automatic compare_outputs(input video_out_t expected);
		check_value(test_name, "vga_r", expected.r, vga_r);
		check_value(test_name, "vga_g", expected.g, vga_g);
		check_value(test_name, "vga_b", expected.b, vga_b);
		check_value(test_name, "vga_hs", expected.hs, vga_hs);
		check_value(test_name, "vga_vs", expected.vs, vga_vs);
		check_value(test_name, "vga_blank_n", expected.blank_n, vga_blank_n);
	endtask

	// One falling edge: check, drive the next pixel, advance
	task automatic video_step();
		logic [31:0] rnd;
		logic active;
		compare_outputs(hist1);
		active = (model_h < `H_ACTIVE) && (model_v < `V_ACTIVE);
		check_value(test_name, "pixel_request", active, pixel_request);
		rnd = $random(seed);
		// Red in the top byte, as in the model's rgb word
		pixel_in_r = rnd[23:16];
		pixel_in_g = rnd[15:8];
		pixel_in_b = rnd[7:0];
		// Two-cycle latency to the pins
		hist1 = hist0;
		hist0 = expected_output(model_h, model_v, rnd[23:0]);
		if (model_h == h_total - 1) begin
			model_h = 0;
			model_v = (model_v == v_total - 1) ? 0 : model_v + 1;
		end else begin
			model_h = model_h + 1;
		end
		if (model_h == 0 && model_v == `V_ACTIVE)
			-> vblank_start;
	endtask

	initial begin : video_side
		reset = 1'b1;
		pixel_in_r = '0;
		pixel_in_g = '0;
		pixel_in_b = '0;
		model_h = 0;
		model_v = 0;
		hist0 = idle_out;
		hist1 = idle_out;
		@(negedge vga_clk);
		compare_outputs(idle_out);
		check_value(test_name, "awready", 0, awready);
		check_value(test_name, "wready", 0, wready);
		check_value(test_name, "bvalid", 0, bvalid);
		check_value(test_name, "arready", 0, arready);
		check_value(test_name, "rvalid", 0, rvalid);
		@(negedge vga_clk);
		reset = 1'b0;
		test_name = "pass_through";
		running = 1'b1;
		forever begin
			video_step();
			@(negedge vga_clk);
		end
	end

	// ============================================================
	// AXI4-Lite host
	// ============================================================
	task automatic start_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge vga_clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
	endtask

	// Returns one cycle after the accept, valids dropped
	task automatic wait_write_accept();
		int waited;
		waited = 0;
		do begin
			@(negedge vga_clk);
			waited++;
			if (waited > handshake_limit)
				fail_run("write address and data were never accepted");
		end while (!(awready && wready));
		@(negedge vga_clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		check_value(test_name, "bvalid_rise", 1, bvalid);
	endtask

	task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		bready = 1'b1;
		start_write(addr, data);
		wait_write_accept();
		check_value(test_name, "bresp", expected_resp(addr), bresp);
		model_write(addr, data);
		@(negedge vga_clk);
		check_value(test_name, "bvalid_clear", 0, bvalid);
	endtask

	task automatic check_read(input logic [`AXI_ADDR_W-1:0] addr);
		int waited;
		waited = 0;
		@(negedge vga_clk);
		araddr = addr;
		arvalid = 1'b1;
		do begin
			@(negedge vga_clk);
			waited++;
			if (waited > handshake_limit)
				fail_run("read address was never accepted");
		end while (!arready);
		@(negedge vga_clk);
		arvalid = 1'b0;
		check_value(test_name, "rvalid_rise", 1, rvalid);
		check_value(test_name, "rresp", expected_resp(addr), rresp);
		check_value(test_name, "rdata", expected_read(addr), rdata);
		@(negedge vga_clk);
		check_value(test_name, "rvalid_clear", 0, rvalid);
	endtask

	task automatic read_all_regs();
		check_read(`ADDR_CTRL);
		check_read(`ADDR_SCORE_A);
		check_read(`ADDR_SCORE_B);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin : host_side
		int score_a;
		int score_b;
		logic [`AXI_ADDR_W-1:0] bad_addr;
		logic [31:0] data;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		wait (running);
		// Frame 0 runs with the overlay off
		@(vblank_start);

		// Scores written in vertical blanking, shown next frame
		test_name = "score_glyphs";
		for (int i = 0; i < 3; i++) begin
			score_a = {$random(seed)} % 100;
			score_b = {$random(seed)} % 100;
			axi_write(`ADDR_SCORE_A, score_a);
			axi_write(`ADDR_SCORE_B, score_b);
			axi_write(`ADDR_CTRL, (i == 1) ? ({$random(seed)} & 1) : 1);
			read_all_regs();
			@(vblank_start);
		end

		// Low 7 bits above 99, upper bits random
		test_name = "saturation";
		data = ({$random(seed)} & 32'hffff_ff80) | (100 + {$random(seed)} % 28);
		axi_write(`ADDR_SCORE_A, data);
		data = ({$random(seed)} & 32'hffff_ff80) | (100 + {$random(seed)} % 28);
		axi_write(`ADDR_SCORE_B, data);
		axi_write(`ADDR_CTRL, 1);
		read_all_regs();
		@(vblank_start);

		test_name = "bus_errors";
		for (int i = 0; i < 8; i++) begin
			do
				bad_addr = $random(seed);
			while (bad_addr == `ADDR_CTRL || bad_addr == `ADDR_SCORE_A ||
				bad_addr == `ADDR_SCORE_B);
			axi_write(bad_addr, $random(seed));
			check_read(bad_addr);
		end
		read_all_regs();

		// Response held back, second write must wait
		test_name = "back_pressure";
		score_a = {$random(seed)} % 100;
		score_b = {$random(seed)} % 100;
		bready = 1'b0;
		start_write(`ADDR_SCORE_A, score_a);
		wait_write_accept();
		check_value(test_name, "bresp", OKAY, bresp);
		model_write(`ADDR_SCORE_A, score_a);
		start_write(`ADDR_SCORE_B, score_b);
		for (int i = 0; i < hold_cycles; i++) begin
			@(negedge vga_clk);
			check_value(test_name, "bvalid_held", 1, bvalid);
			check_value(test_name, "awready_blocked", 0, awready);
		end
		bready = 1'b1;
		@(negedge vga_clk);
		check_value(test_name, "bvalid_taken", 0, bvalid);
		wait_write_accept();
		check_value(test_name, "bresp", OKAY, bresp);
		model_write(`ADDR_SCORE_B, score_b);
		@(negedge vga_clk);
		check_value(test_name, "bvalid_clear", 0, bvalid);
		read_all_regs();

		// One more frame with the final scores
		test_name = "final_frame";
		@(vblank_start);

		$display("Simulation passed");
		$finish;
	end

	// Watchdog
	initial begin : watchdog
		#(timeout_ns);
		fail_run("timeout: the tests did not finish within the expected time");
	end

endmodule

`default_nettype wire

/* hdl/score_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

`include "score_overlay_defines.svh"

module score_overlay (
	input wire logic vga_clk,
	input wire logic reset,
	// Host register bus
	input wire logic [`AXI_ADDR_W-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [`AXI_DATA_W-1:0] wdata,
	input wire logic wvalid,
	output logic wready,
	output score_overlay_pkg::axi_resp_t bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [`AXI_ADDR_W-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [`AXI_DATA_W-1:0] rdata,
	output score_overlay_pkg::axi_resp_t rresp,
	output logic rvalid,
	input wire logic rready,
	// Incoming video
	output logic pixel_request,
	input wire logic [7:0] pixel_in_r,
	input wire logic [7:0] pixel_in_g,
	input wire logic [7:0] pixel_in_b,
	// VGA pins
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n
);

	import score_overlay_pkg::*;

	logic [`COUNT_W-1:0] h_count;
	logic [`COUNT_W-1:0] v_count;
	sync_t sync_raw;
	sync_t sync_dly;
	pixel_t pixel_dly;
	logic overlay_enable;
	digit_t digits [`NUM_DIGITS];
	logic [`NUM_DIGITS-1:0] lit;

	// ============================================================
	// Timing and registers
	// ============================================================
	vga_timing u_timing (
		.vga_clk(vga_clk),
		.reset(reset),
		.h_count(h_count),
		.v_count(v_count),
		.sync(sync_raw),
		.pixel_request(pixel_request)
	);

	score_regs u_regs (
		.vga_clk(vga_clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.overlay_enable(overlay_enable),
		.digits(digits)
	);

	// ============================================================
	// Glyph stage, tens and ones of score A then score B
	// ============================================================
	for (genvar k = 0; k < `NUM_DIGITS; k++) begin : g_glyph
		digit_glyph #(
			.origin_x(`GLYPH_X0 + `GLYPH_PITCH * k)
		) u_glyph (
			.vga_clk(vga_clk),
			.reset(reset),
			.h_count(h_count),
			.v_count(v_count),
			.digit(digits[k]),
			.lit(lit[k])
		);
	end

	// Pixel and syncs wait one cycle for the glyph flags
	video_delay #(.payload_t(pixel_t), .depth(1)) u_pixel_delay (
		.vga_clk(vga_clk),
		.reset(reset),
		.din({pixel_in_r, pixel_in_g, pixel_in_b}),
		.dout(pixel_dly)
	);

	video_delay #(.payload_t(sync_t), .depth(1)) u_sync_delay (
		.vga_clk(vga_clk),
		.reset(reset),
		.din(sync_raw),
		.dout(sync_dly)
	);

	overlay_mixer u_mixer (
		.vga_clk(vga_clk),
		.reset(reset),
		.overlay_enable(overlay_enable),
		.lit(lit),
		.pixel(pixel_dly),
		.sync(sync_dly),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_blank_n(vga_blank_n)
	);

endmodule

`default_nettype wire

/* hdl/overlay_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "score_overlay_defines.svh"

module overlay_mixer (
	input wire logic vga_clk,
	input wire logic reset,
	input wire logic overlay_enable,
	input wire logic [`NUM_DIGITS-1:0] lit,
	input wire score_overlay_pkg::pixel_t pixel,
	input wire score_overlay_pkg::sync_t sync,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n
);

	logic glyph_on;
	// Delay stage still holds its cleared value right after reset
	logic pipe_full;

	// Any lit glyph, only when enabled
	assign glyph_on = overlay_enable && (|lit);

	// ============================================================
	// Output registers
	// ============================================================
	always_ff @(posedge vga_clk) begin
		if (reset) begin
			pipe_full <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			pipe_full <= 1'b1;
			// Idle syncs until real timing arrives
			vga_hs <= sync.hsync || !pipe_full;
			vga_vs <= sync.vsync || !pipe_full;
			vga_blank_n <= sync.active;
			if (!sync.active) begin
				// Black in blanking
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end else if (glyph_on) begin
				vga_r <= 8'hff;
				vga_g <= 8'hff;
				vga_b <= 8'hff;
			end else begin
				vga_r <= pixel.r;
				vga_g <= pixel.g;
				vga_b <= pixel.b;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/video_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module video_delay #(
	parameter type payload_t = logic,
	parameter int depth = 1
) (
	input wire logic vga_clk,
	input wire logic reset,
	input wire payload_t din,
	output payload_t dout
);

	// Register chain, stage 0 nearest the input
	payload_t stages [depth];

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++)
				stages[i] <= '0;
		end else begin
			stages[0] <= din;
			// Shift the rest along
			for (int i = 1; i < depth; i++)
				stages[i] <= stages[i-1];
		end
	end

	assign dout = stages[depth-1];

endmodule

`default_nettype wire

/* hdl/digit_glyph.sv */
`timescale 1ns/1ps
`default_nettype none

`include "score_overlay_defines.svh"

module digit_glyph #(
	parameter int origin_x = `GLYPH_X0
) (
	input wire logic vga_clk,
	input wire logic reset,
	input wire logic [`COUNT_W-1:0] h_count,
	input wire logic [`COUNT_W-1:0] v_count,
	input wire score_overlay_pkg::digit_t digit,
	output logic lit
);

	// Middle row split and bar of segment g
	localparam int half_h = `GLYPH_H / 2;
	localparam int right_x = `GLYPH_W - `SEG_T;

	int local_x;
	int local_y;
	logic in_box;
	// Bit order g f e d c b a
	logic [6:0] seg_on;
	logic [6:0] seg_hit;

	// Position relative to the glyph origin
	assign local_x = int'(h_count) - origin_x;
	assign local_y = int'(v_count) - `GLYPH_Y;
	assign in_box = (local_x >= 0) && (local_x < `GLYPH_W) &&
		(local_y >= 0) && (local_y < `GLYPH_H);

	// Segment set per digit
	always_comb begin
		case (digit)
			4'd0: seg_on = 7'b0111111;
			4'd1: seg_on = 7'b0000110;
			4'd2: seg_on = 7'b1011011;
			4'd3: seg_on = 7'b1001111;
			4'd4: seg_on = 7'b1100110;
			4'd5: seg_on = 7'b1101101;
			4'd6: seg_on = 7'b1111101;
			4'd7: seg_on = 7'b0000111;
			4'd8: seg_on = 7'b1111111;
			4'd9: seg_on = 7'b1101111;
			default: seg_on = 7'b0000000;
		endcase
	end

	// ============================================================
	// Segment rectangles
	// ============================================================
	assign seg_hit[0] = (local_y < `SEG_T);
	assign seg_hit[1] = (local_x >= right_x) && (local_y < half_h);
	assign seg_hit[2] = (local_x >= right_x) && (local_y >= half_h);
	assign seg_hit[3] = (local_y >= `GLYPH_H - `SEG_T);
	assign seg_hit[4] = (local_x < `SEG_T) && (local_y >= half_h);
	assign seg_hit[5] = (local_x < `SEG_T) && (local_y < half_h);
	// Centre bar straddles the split
	assign seg_hit[6] = (local_y >= half_h - `SEG_T / 2) && (local_y < half_h + `SEG_T / 2);

	// One cycle after the counters
	always_ff @(posedge vga_clk) begin
		if (reset)
			lit <= 1'b0;
		else
			lit <= in_box && |(seg_on & seg_hit);
	end

endmodule

`default_nettype wire

/* hdl/score_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "score_overlay_defines.svh"

module score_regs (
	input wire logic vga_clk,
	input wire logic reset,
	input wire logic [`AXI_ADDR_W-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [`AXI_DATA_W-1:0] wdata,
	input wire logic wvalid,
	output logic wready,
	output score_overlay_pkg::axi_resp_t bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [`AXI_ADDR_W-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [`AXI_DATA_W-1:0] rdata,
	output score_overlay_pkg::axi_resp_t rresp,
	output logic rvalid,
	input wire logic rready,
	output logic overlay_enable,
	output score_overlay_pkg::digit_t digits [`NUM_DIGITS]
);

	import score_overlay_pkg::*;

	localparam logic [6:0] score_max = 7'(`SCORE_MAX);

	logic [6:0] score_a;
	logic [6:0] score_b;
	logic [6:0] wr_score;
	logic write_fire;
	logic read_fire;
	logic [`AXI_DATA_W-1:0] rd_data_next;
	axi_resp_t rd_resp_next;

	function automatic digit_t tens_of(input logic [6:0] value);
		logic [6:0] tens;
		tens = value / 7'd10;
		return tens[3:0];
	endfunction

	function automatic digit_t ones_of(input logic [6:0] value);
		logic [6:0] ones;
		ones = value % 7'd10;
		return ones[3:0];
	endfunction

	// ============================================================
	// Write channel
	// ============================================================

	// Address and data taken together
	assign write_fire = awready && awvalid && wvalid;
	assign wready = awready;

	// Clamp incoming score
	assign wr_score = (wdata[6:0] > score_max) ? score_max : wdata[6:0];

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			awready <= 1'b0;
			bvalid <= 1'b0;
			overlay_enable <= 1'b0;
			score_a <= '0;
			score_b <= '0;
			for (int i = 0; i < `NUM_DIGITS; i++)
				digits[i] <= '0;
		end else begin
			// One-cycle ready, held off while a response waits
			awready <= !awready && awvalid && wvalid && !bvalid;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (write_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					`ADDR_CTRL: overlay_enable <= wdata[0];
					`ADDR_SCORE_A: begin
						score_a <= wr_score;
						digits[0] <= tens_of(wr_score);
						digits[1] <= ones_of(wr_score);
					end
					`ADDR_SCORE_B: begin
						score_b <= wr_score;
						digits[2] <= tens_of(wr_score);
						digits[3] <= ones_of(wr_score);
					end
					default: ;
				endcase
			end
		end
	end

	// Response code follows the decode
	always_ff @(posedge vga_clk) begin
		if (write_fire) begin
			if (awaddr == `ADDR_CTRL || awaddr == `ADDR_SCORE_A || awaddr == `ADDR_SCORE_B)
				bresp <= OKAY;
			else
				bresp <= SLVERR;
		end
	end

	// ============================================================
	// Read channel
	// ============================================================
	assign read_fire = arready && arvalid;

	// Readback mux, unmapped gives zero
	always_comb begin
		rd_data_next = '0;
		rd_resp_next = OKAY;
		case (araddr)
			`ADDR_CTRL: rd_data_next[0] = overlay_enable;
			`ADDR_SCORE_A: rd_data_next[6:0] = score_a;
			`ADDR_SCORE_B: rd_data_next[6:0] = score_b;
			default: rd_resp_next = SLVERR;
		endcase
	end

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= !arready && arvalid && !rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (read_fire)
				rvalid <= 1'b1;
		end
	end

	// Read payload
	always_ff @(posedge vga_clk) begin
		if (read_fire) begin
			rdata <= rd_data_next;
			rresp <= rd_resp_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "score_overlay_defines.svh"

module vga_timing (
	input wire logic vga_clk,
	input wire logic reset,
	output logic [`COUNT_W-1:0] h_count,
	output logic [`COUNT_W-1:0] v_count,
	output score_overlay_pkg::sync_t sync,
	output logic pixel_request
);

	// Period totals and sync windows
	localparam int h_total = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int v_total = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int h_sync_start = `H_ACTIVE + `H_FRONT;
	localparam int h_sync_end = h_sync_start + `H_SYNC;
	localparam int v_sync_start = `V_ACTIVE + `V_FRONT;
	localparam int v_sync_end = v_sync_start + `V_SYNC;

	logic active;
	logic line_end;

	// Last clock of a line
	assign line_end = (int'(h_count) == h_total - 1);

	// ============================================================
	// Counters
	// ============================================================
	always_ff @(posedge vga_clk) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else begin
			if (line_end) begin
				h_count <= '0;
				// Vertical advances once per line
				if (int'(v_count) == v_total - 1)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	// Visible area
	assign active = (int'(h_count) < `H_ACTIVE) && (int'(v_count) < `V_ACTIVE);

	// Sync pulses, low inside their window
	assign sync.hsync = !((int'(h_count) >= h_sync_start) && (int'(h_count) < h_sync_end));
	assign sync.vsync = !((int'(v_count) >= v_sync_start) && (int'(v_count) < v_sync_end));
	assign sync.active = active;

	// Source presents a pixel in every active cycle
	assign pixel_request = active;

endmodule

`default_nettype wire

/* hdl/score_overlay_pkg.sv */
`default_nettype none

package score_overlay_pkg;

	// ============================================================
	// Video payloads
	// ============================================================

	// One RGB pixel, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// Syncs are active low, active marks the visible area
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
	} sync_t;

	// One decimal digit, 0 to 9
	typedef logic [3:0] digit_t;

	// ============================================================
	// Host bus
	// ============================================================
	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axi_resp_t;

endpackage

`default_nettype wire

/* hdl/score_overlay_defines.svh */
`ifndef SCORE_OVERLAY_DEFINES_SVH
`define SCORE_OVERLAY_DEFINES_SVH

// 640x480 at 60 Hz, 800 clocks per line
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
// 525 lines per frame
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define COUNT_W 10

// Glyph box and placement
`define GLYPH_W 16
`define GLYPH_H 24
`define SEG_T 4
`define GLYPH_X0 32
`define GLYPH_PITCH 24
`define GLYPH_Y 16
`define NUM_DIGITS 4
`define SCORE_MAX 99

// Host register map
`define ADDR_CTRL 4'h0
`define ADDR_SCORE_A 4'h4
`define ADDR_SCORE_B 4'h8
`define AXI_ADDR_W 4
`define AXI_DATA_W 32

`endif
